//--- include/io_defs.svh
// ======================================================================
// IO region code, register word indices, receive queue depth
// and default prescaler and bit-period divisors
// ======================================================================
`ifndef IO_DEFS_SVH
`define IO_DEFS_SVH

// address map
`define IO_REGION          4'hE   // top nibble of an IO address
`define IO_IDX_MS          4'd0   // millisecond counter
`define IO_IDX_LED         4'd1   // led register, reads as zero
`define IO_IDX_UART_DATA   4'd2   // rx byte / tx byte
`define IO_IDX_UART_CTRL   4'd3   // status / dequeue and rate

// receive queue
`define RX_FIFO_DEPTH      16     // power of two

// defaults for a 25 MHz clk_cpu
`define CLKS_PER_MS_DFLT   25000
`define BAUD_DIV_SLOW_DFLT 1302   // about 19200 baud
`define BAUD_DIV_FAST_DFLT 217    // about 115200 baud

`endif

//--- logic/io_pkg.sv
// ======================================================================
// bus request, IO address and serial status types
// ======================================================================
package io_pkg;

    typedef logic [7:0] byte_t;

    // 32-bit address split for the IO decoder
    typedef struct packed {
        logic [3:0]  region;   // E selects IO
        logic [21:0] unused;
        logic [3:0]  index;    // register word index
        logic [1:0]  offset;   // byte within word
    } io_addr_t;

    // one request per cycle from the bus master
    typedef struct packed {
        logic        rd;
        logic        wr;
        io_addr_t    addr;
        logic [31:0] wdata;
    } io_req_t;

    // serial status word read at index 3
    typedef struct packed {
        logic [29:0] pad;      // always zero
        logic        tx_ready; // transmitter idle
        logic        rx_ready; // queue holds a byte
    } uart_status_t;

endpackage

//--- logic/ms_timer.sv
// ======================================================================
// prescaler and free-running millisecond counter
// ======================================================================
module ms_timer #(
    parameter int CLKS_PER_MS = 25000
) (
    input  logic        clk_cpu,
    input  logic        rst_n,
    output logic [31:0] ms_count_o
);
    import io_pkg::*;

    localparam int PW = (CLKS_PER_MS > 1) ? $clog2(CLKS_PER_MS) : 1;
    localparam logic [PW-1:0] PRE_LAST = PW'(CLKS_PER_MS - 1);

    logic [PW-1:0] pre_cnt;
    logic          wrap;

    assign wrap = (pre_cnt == PRE_LAST);

    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            pre_cnt    <= '0;
            ms_count_o <= '0;
        end else begin
            pre_cnt <= wrap ? '0 : pre_cnt + 1'b1;
            if (wrap) begin
                ms_count_o <= ms_count_o + 32'd1;   // wraps after 2^32 ms
            end
        end
    end

endmodule

//--- logic/uart_tx.sv
// ======================================================================
// serial transmitter, 8N1, two selectable bit periods
// ======================================================================
module uart_tx #(
    parameter int BAUD_DIV_SLOW = 1302,
    parameter int BAUD_DIV_FAST = 217
) (
    input  logic          clk_cpu,
    input  logic          rst_n,
    input  logic          start_i,
    input  io_pkg::byte_t byte_i,
    input  logic          rate_fast_i,
    output logic          tx_o,
    output logic          ready_o
);
    import io_pkg::*;

    localparam int DIV_MAX = (BAUD_DIV_SLOW > BAUD_DIV_FAST) ? BAUD_DIV_SLOW : BAUD_DIV_FAST;
    localparam int CW = $clog2(DIV_MAX + 1);
    localparam logic [CW-1:0] SLOW_LAST = CW'(BAUD_DIV_SLOW - 1);
    localparam logic [CW-1:0] FAST_LAST = CW'(BAUD_DIV_FAST - 1);

    logic          busy;
    logic          rate_q;     // divisor choice held for the frame
    logic [CW-1:0] div_cnt;
    logic [3:0]    bits_left;  // data bits plus stop still to send
    logic [8:0]    shreg;      // {stop, data}

    assign ready_o = !busy;

    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            rate_q    <= 1'b0;
            div_cnt   <= '0;
            bits_left <= '0;
            tx_o      <= 1'b1;
        end else if (!busy) begin
            if (start_i) begin
                busy      <= 1'b1;
                rate_q    <= rate_fast_i;
                div_cnt   <= rate_fast_i ? FAST_LAST : SLOW_LAST;
                bits_left <= 4'd9;
                tx_o      <= 1'b0;   // start bit
            end
        end else if (div_cnt != '0) begin
            div_cnt <= div_cnt - 1'b1;
        end else if (bits_left == 4'd0) begin
            busy <= 1'b0;            // stop bit done, line stays high
        end else begin
            tx_o      <= shreg[0];
            bits_left <= bits_left - 4'd1;
            div_cnt   <= rate_q ? FAST_LAST : SLOW_LAST;
        end
    end

    always_ff @(posedge clk_cpu) begin
        if (!busy && start_i) begin
            shreg <= {1'b1, byte_i};
        end else if (busy && (div_cnt == '0) && (bits_left != 4'd0)) begin
            shreg <= {1'b1, shreg[8:1]};   // lsb first
        end
    end

endmodule

//--- logic/uart_rx.sv
// ======================================================================
// serial receiver, 8N1, mid-bit sampling with stop bit check
// ======================================================================
module uart_rx #(
    parameter int BAUD_DIV_SLOW = 1302,
    parameter int BAUD_DIV_FAST = 217
) (
    input  logic          clk_cpu,
    input  logic          rst_n,
    input  logic          rx_i,
    input  logic          rate_fast_i,
    output logic          valid_o,
    output io_pkg::byte_t byte_o
);
    import io_pkg::*;

    localparam int DIV_MAX = (BAUD_DIV_SLOW > BAUD_DIV_FAST) ? BAUD_DIV_SLOW : BAUD_DIV_FAST;
    localparam int CW = $clog2(DIV_MAX + 1);
    localparam logic [CW-1:0] SLOW_LAST = CW'(BAUD_DIV_SLOW - 1);
    localparam logic [CW-1:0] FAST_LAST = CW'(BAUD_DIV_FAST - 1);
    localparam logic [CW-1:0] SLOW_HALF = CW'(BAUD_DIV_SLOW / 2 - 1);
    localparam logic [CW-1:0] FAST_HALF = CW'(BAUD_DIV_FAST / 2 - 1);

    typedef enum logic [1:0] {IDLE, START, DATA, STOP} rx_state_t;

    rx_state_t     state;
    logic [2:0]    rx_sync;    // two sync flops plus edge history
    logic          rx_s;
    logic          rate_q;
    logic [CW-1:0] div_cnt;
    logic [2:0]    bit_idx;
    byte_t         shreg;

    assign rx_s   = rx_sync[1];
    assign byte_o = shreg;

    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            rx_sync <= 3'b111;       // idle line is high
            state   <= IDLE;
            rate_q  <= 1'b0;
            div_cnt <= '0;
            bit_idx <= '0;
            valid_o <= 1'b0;
        end else begin
            rx_sync <= {rx_sync[1:0], rx_i};
            valid_o <= 1'b0;
            if (state != IDLE && div_cnt != '0) begin
                div_cnt <= div_cnt - 1'b1;
            end else begin
                case (state)
                    IDLE: if (rx_sync[2] && !rx_s) begin   // falling edge
                        state   <= START;
                        rate_q  <= rate_fast_i;
                        div_cnt <= rate_fast_i ? FAST_HALF : SLOW_HALF;
                    end
                    START: begin
                        state   <= rx_s ? IDLE : DATA;      // glitch rejected
                        bit_idx <= '0;
                        div_cnt <= rate_q ? FAST_LAST : SLOW_LAST;
                    end
                    DATA: begin
                        bit_idx <= bit_idx + 3'd1;
                        div_cnt <= rate_q ? FAST_LAST : SLOW_LAST;
                        if (bit_idx == 3'd7) begin
                            state <= STOP;
                        end
                    end
                    default: begin                          // mid stop bit
                        valid_o <= rx_s;                    // framing error drops byte
                        state   <= IDLE;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk_cpu) begin
        if (state == DATA && div_cnt == '0) begin
            shreg <= {rx_s, shreg[7:1]};   // lsb arrives first
        end
    end

endmodule

//--- logic/rx_fifo.sv
// ======================================================================
// synchronous receive queue, circular buffer with wide pointers
// ======================================================================
`include "io_defs.svh"

module rx_fifo (
    input  logic          clk_cpu,
    input  logic          rst_n,
    input  logic          enq_i,
    input  io_pkg::byte_t data_i,
    input  logic          deq_i,
    output io_pkg::byte_t head_o,
    output logic          empty_o,
    output logic          full_o
);
    import io_pkg::*;

    localparam int DEPTH = `RX_FIFO_DEPTH;
    localparam int AW = $clog2(DEPTH);

    byte_t       mem [DEPTH];
    logic [AW:0] wr_ptr;       // extra bit tells full from empty
    logic [AW:0] rd_ptr;
    logic        do_enq;
    logic        do_deq;

    assign empty_o = (wr_ptr == rd_ptr);
    assign full_o  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign head_o  = mem[rd_ptr[AW-1:0]];

    assign do_enq = enq_i && !full_o;    // byte lost when full
    assign do_deq = deq_i && !empty_o;

    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_enq) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_deq) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_cpu) begin
        if (do_enq) begin
            mem[wr_ptr[AW-1:0]] <= data_i;
        end
    end

endmodule

//--- logic/io_regs.sv
// ======================================================================
// IO decoder, write strobes, led / rate / receive byte registers
// and the combinational read multiplexer
// ======================================================================
`include "io_defs.svh"

module io_regs (
    input  logic            clk_cpu,
    input  logic            rst_n,
    input  io_pkg::io_req_t io_req_i,
    output logic [31:0]     io_rdata_o,
    input  logic [31:0]     ms_count_i,
    input  logic            tx_ready_i,
    output logic            tx_start_o,
    output io_pkg::byte_t   tx_byte_o,
    output logic            rate_fast_o,
    input  logic            fifo_empty_i,
    input  io_pkg::byte_t   fifo_head_i,
    output logic            deq_o,
    output io_pkg::byte_t   led_o
);
    import io_pkg::*;

    logic         io_sel;
    logic         wr_io;
    logic [3:0]   widx;
    logic         tx_accept;
    byte_t        rx_byte_q;    // last dequeued byte
    uart_status_t status;

    assign io_sel = (io_req_i.addr.region == `IO_REGION);
    assign wr_io  = io_req_i.wr && io_sel;
    assign widx   = io_req_i.addr.index;

    // a data write while busy or with a start pending is dropped
    assign tx_accept = wr_io && (widx == `IO_IDX_UART_DATA) && tx_ready_i && !tx_start_o;

    assign status = '{pad: '0, tx_ready: tx_ready_i, rx_ready: !fifo_empty_i};

    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            tx_start_o  <= 1'b0;
            deq_o       <= 1'b0;
            led_o       <= '0;
            rate_fast_o <= 1'b0;
            rx_byte_q   <= '0;
        end else begin
            tx_start_o <= tx_accept;
            deq_o      <= wr_io && (widx == `IO_IDX_UART_CTRL) && !fifo_empty_i;
            if (wr_io && (widx == `IO_IDX_LED)) begin
                led_o <= io_req_i.wdata[7:0];
            end
            if (wr_io && (widx == `IO_IDX_UART_CTRL)) begin
                rate_fast_o <= io_req_i.wdata[0];   // bit 0 picks the rate
            end
            if (deq_o) begin
                rx_byte_q <= fifo_head_i;           // head before the pop
            end
        end
    end

    // byte handed to the transmitter with the start strobe
    always_ff @(posedge clk_cpu) begin
        if (tx_accept) begin
            tx_byte_o <= io_req_i.wdata[7:0];
        end
    end

    always_comb begin
        io_rdata_o = '0;
        if (io_req_i.rd && io_sel) begin
            case (widx)
                `IO_IDX_MS:        io_rdata_o = ms_count_i;
                `IO_IDX_UART_DATA: io_rdata_o = {24'd0, rx_byte_q};
                `IO_IDX_UART_CTRL: io_rdata_o = status;
                default:           io_rdata_o = '0;   // led and unused words
            endcase
        end
    end

endmodule

//--- logic/io_hub.sv
// ======================================================================
// memory-mapped peripheral block: decoder, timer, serial port
// and receive queue
// ======================================================================
`include "io_defs.svh"

module io_hub #(
    parameter int CLKS_PER_MS   = `CLKS_PER_MS_DFLT,
    parameter int BAUD_DIV_SLOW = `BAUD_DIV_SLOW_DFLT,
    parameter int BAUD_DIV_FAST = `BAUD_DIV_FAST_DFLT
) (
    input  logic            clk_cpu,
    input  logic            rst_n,
    input  io_pkg::io_req_t io_req_i,
    output logic [31:0]     io_rdata_o,
    input  logic            rx_i,
    output logic            tx_o,
    output io_pkg::byte_t   led_o
);
    import io_pkg::*;

    logic [31:0] ms_count;
    logic        tx_ready;
    logic        tx_start;
    byte_t       tx_byte;
    logic        rate_fast;   // 1 selects BAUD_DIV_FAST
    logic        fifo_empty;
    byte_t       fifo_head;
    logic        deq;
    logic        rx_valid;
    byte_t       rx_byte;

    io_regs i_regs (
        .clk_cpu      (clk_cpu),
        .rst_n        (rst_n),
        .io_req_i     (io_req_i),
        .io_rdata_o   (io_rdata_o),
        .ms_count_i   (ms_count),
        .tx_ready_i   (tx_ready),
        .tx_start_o   (tx_start),
        .tx_byte_o    (tx_byte),
        .rate_fast_o  (rate_fast),
        .fifo_empty_i (fifo_empty),
        .fifo_head_i  (fifo_head),
        .deq_o        (deq),
        .led_o        (led_o)
    );

    ms_timer #(.CLKS_PER_MS(CLKS_PER_MS)) i_timer (
        .clk_cpu    (clk_cpu),
        .rst_n      (rst_n),
        .ms_count_o (ms_count)
    );

    uart_tx #(.BAUD_DIV_SLOW(BAUD_DIV_SLOW), .BAUD_DIV_FAST(BAUD_DIV_FAST)) i_tx (
        .clk_cpu     (clk_cpu),
        .rst_n       (rst_n),
        .start_i     (tx_start),
        .byte_i      (tx_byte),
        .rate_fast_i (rate_fast),
        .tx_o        (tx_o),
        .ready_o     (tx_ready)
    );

    uart_rx #(.BAUD_DIV_SLOW(BAUD_DIV_SLOW), .BAUD_DIV_FAST(BAUD_DIV_FAST)) i_rx (
        .clk_cpu     (clk_cpu),
        .rst_n       (rst_n),
        .rx_i        (rx_i),
        .rate_fast_i (rate_fast),
        .valid_o     (rx_valid),
        .byte_o      (rx_byte)
    );

    rx_fifo i_fifo (
        .clk_cpu (clk_cpu),
        .rst_n   (rst_n),
        .enq_i   (rx_valid),
        .data_i  (rx_byte),
        .deq_i   (deq),
        .head_o  (fifo_head),
        .empty_o (fifo_empty),
        .full_o  ()            // used only by the enqueue guard
    );

endmodule

//--- verif/io_hub_chk.sv
// ======================================================================
// concurrent assertions on the io_hub top level, bound to io_hub
// ======================================================================
`include "io_defs.svh"

module io_hub_chk (
    input logic            clk_cpu,
    input logic            rst_n,
    input io_pkg::io_req_t io_req_i,
    input logic            tx_o,
    input io_pkg::byte_t   led_o,
    input logic            tx_ready,
    input logic            deq,
    input logic            fifo_empty,
    input io_pkg::byte_t   rx_byte_q
);
    timeunit 1ns;
    timeprecision 100ps;
    import io_pkg::*;

    logic led_wr;

    assign led_wr = io_req_i.wr && (io_req_i.addr.region == `IO_REGION)
                    && (io_req_i.addr.index == `IO_IDX_LED);

    a_idle_line: assert property (@(posedge clk_cpu) disable iff (!rst_n) tx_ready |-> tx_o)
        else $error("tx_o low while the transmitter is idle");

    a_deq_nonempty: assert property (@(posedge clk_cpu) disable iff (!rst_n) deq |-> !fifo_empty)
        else $error("receive queue dequeued while empty");

    a_led_write: assert property (@(posedge clk_cpu) disable iff (!rst_n)
        $changed(led_o) |-> $past(led_wr))
        else $error("led_o changed without a write to the led word");

    a_rx_byte: assert property (@(posedge clk_cpu) disable iff (!rst_n)
        $changed(rx_byte_q) |-> $past(deq))
        else $error("receive byte register changed without a dequeue");

endmodule

bind io_hub io_hub_chk i_chk (
    .clk_cpu    (clk_cpu),
    .rst_n      (rst_n),
    .io_req_i   (io_req_i),
    .tx_o       (tx_o),
    .led_o      (led_o),
    .tx_ready   (tx_ready),
    .deq        (deq),
    .fifo_empty (fifo_empty),
    .rx_byte_q  (i_regs.rx_byte_q)
);

//--- verif/tb_io_hub.sv
// ======================================================================
// testbench for io_hub: bus master, serial driver and monitor,
// reference model, compare process and test sequence
// ======================================================================
`include "io_defs.svh"

module tb_io_hub;
    timeunit 1ns;
    timeprecision 100ps;
    import io_pkg::*;

    localparam int MS_CYCLES = 40;
    localparam int DIV_SLOW  = 16;
    localparam int DIV_FAST  = 8;
    localparam int K_WORD    = 0;
    localparam int K_BYTE    = 1;
    localparam int K_STATUS  = 2;

    typedef struct {
        int          kind;
        logic [31:0] got;
        logic [31:0] exp;
        string       what;
    } check_t;

    logic        clk_cpu;
    logic        rst_n;
    io_req_t     req;
    logic [31:0] rdata;
    logic        rx_i;
    logic        tx_o;
    byte_t       led;

    check_t      checks[$];    // results waiting for the compare process
    byte_t       rxq[$];       // model of the receive queue
    byte_t       led_m;
    logic        rate_m;
    logic        txr_m;
    byte_t       last_byte;    // model of the receive byte register
    int          cycles;       // posedges since reset release
    int unsigned lcg_state;

    io_hub #(
        .CLKS_PER_MS   (MS_CYCLES),
        .BAUD_DIV_SLOW (DIV_SLOW),
        .BAUD_DIV_FAST (DIV_FAST)
    ) i_dut (
        .clk_cpu    (clk_cpu),
        .rst_n      (rst_n),
        .io_req_i   (req),
        .io_rdata_o (rdata),
        .rx_i       (rx_i),
        .tx_o       (tx_o),
        .led_o      (led)
    );

    always #2 clk_cpu = ~clk_cpu;

    always @(posedge clk_cpu) begin
        if (rst_n) begin
            cycles <= cycles + 1;
        end
    end

    function automatic byte_t rand_byte();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[23:16];
    endfunction

    // expected read word at an IO index
    function automatic logic [31:0] expect_word(input logic [3:0] idx, input byte_t led_v,
            input logic rate_v, input byte_t q[$], input byte_t last_b, input logic txr,
            input int cyc);
        uart_status_t st;
        st = '{pad: '0, tx_ready: txr, rx_ready: (q.size() != 0)};
        case (idx)
            `IO_IDX_MS:        return cyc / MS_CYCLES;
            `IO_IDX_UART_DATA: return {24'd0, last_b};
            `IO_IDX_UART_CTRL: return st;
            default:           return 32'd0;   // led word and unused words
        endcase
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic compare_word(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            fail_run($sformatf("** Error at %0d ns: %s, got %h expected %h",
                               $time, what, got, exp));
        end
    endtask

    task automatic compare_byte(input byte_t got, input byte_t exp, input string what);
        if (got !== exp) begin
            fail_run($sformatf("** Error at %0d ns: %s, got %h expected %h",
                               $time, what, got, exp));
        end
    endtask

    task automatic compare_status(input uart_status_t got, input uart_status_t exp,
            input string what);
        if (got !== exp) begin
            fail_run({$sformatf("** Error at %0d ns: %s, got tx_ready %b rx_ready %b pad %h",
                                $time, what, got.tx_ready, got.rx_ready, got.pad),
                      $sformatf(", expected tx_ready %b rx_ready %b",
                                exp.tx_ready, exp.rx_ready)});
        end
    endtask

    always @(posedge clk_cpu) begin
        check_t c;
        while (checks.size() > 0) begin
            c = checks.pop_front();
            case (c.kind)
                K_WORD:  compare_word(c.got, c.exp, c.what);
                K_BYTE:  compare_byte(byte_t'(c.got), byte_t'(c.exp), c.what);
                default: compare_status(uart_status_t'(c.got), uart_status_t'(c.exp), c.what);
            endcase
        end
    end

    task automatic queue_check(input int kind, input logic [31:0] got, input logic [31:0] exp,
            input string what);
        checks.push_back('{kind, got, exp, what});
    endtask

    task automatic write_reg(input logic [3:0] region, input logic [3:0] idx,
            input logic [31:0] data);
        @(negedge clk_cpu);
        req.rd    = 1'b0;
        req.wr    = 1'b1;
        req.addr  = '{region: region, unused: '0, index: idx, offset: 2'b00};
        req.wdata = data;
        @(negedge clk_cpu);
        req.wr = 1'b0;
    endtask

    task automatic read_reg(input logic [3:0] region, input logic [3:0] idx,
            output logic [31:0] data, output int cyc);
        @(negedge clk_cpu);
        req.rd   = 1'b1;
        req.wr   = 1'b0;
        req.addr = '{region: region, unused: '0, index: idx, offset: 2'b00};
        #1;                      // combinational result settles
        data = rdata;
        cyc  = cycles;
        @(negedge clk_cpu);
        req.rd = 1'b0;
    endtask

    task automatic expect_read(input logic [3:0] idx, input string what);
        logic [31:0] got;
        int          cyc;
        read_reg(`IO_REGION, idx, got, cyc);
        queue_check((idx == `IO_IDX_UART_CTRL) ? K_STATUS : K_WORD, got,
                    expect_word(idx, led_m, rate_m, rxq, last_byte, txr_m, cyc), what);
    endtask

    task automatic dequeue_byte();
        write_reg(`IO_REGION, `IO_IDX_UART_CTRL, {31'd0, rate_m});   // rate bit kept
        if (rxq.size() > 0) begin
            last_byte = rxq.pop_front();
        end
    endtask

    // polls the status word until one bit reaches a level
    task automatic wait_status(input int pos, input logic level, input string what);
        logic [31:0] w;
        int          cyc;
        int          n;
        n = 0;
        read_reg(`IO_REGION, `IO_IDX_UART_CTRL, w, cyc);
        while (w[pos] !== level) begin
            n++;
            if (n > 200) begin
                fail_run({"timeout: ", what});
            end
            read_reg(`IO_REGION, `IO_IDX_UART_CTRL, w, cyc);
        end
    endtask

    task automatic send_frame(input byte_t b, input int div);
        @(negedge clk_cpu);
        rx_i = 1'b0;             // start bit
        repeat (div) @(negedge clk_cpu);
        for (int i = 0; i < 8; i++) begin
            rx_i = b[i];
            repeat (div) @(negedge clk_cpu);
        end
        rx_i = 1'b1;             // stop bit
        repeat (div) @(negedge clk_cpu);
    endtask

    task automatic capture_frame(input int div, output byte_t data, output int start_len,
            output logic stop_bit);
        int n;
        n = 0;
        @(negedge clk_cpu);
        while (tx_o !== 1'b0) begin
            n++;
            if (n > 40 * div) begin
                fail_run("timeout: no start bit appeared on tx_o");
            end
            @(negedge clk_cpu);
        end
        start_len = 0;
        while (tx_o === 1'b0 && start_len <= 2 * div) begin
            start_len++;
            @(negedge clk_cpu);
        end
        repeat (div / 2 - 1) @(negedge clk_cpu);   // to the middle of bit 0
        for (int i = 0; i < 8; i++) begin
            data[i] = tx_o;
            repeat (div) @(negedge clk_cpu);
        end
        stop_bit = tx_o;
    endtask

    task automatic transmit_case(input logic fast);
        byte_t b;
        byte_t got;
        int    div;
        int    slen;
        int    lows;
        logic  stop_b;
        div    = fast ? DIV_FAST : DIV_SLOW;
        b      = rand_byte() | 8'h01;   // bit 0 high ends the start bit cleanly
        rate_m = fast;
        write_reg(`IO_REGION, `IO_IDX_UART_CTRL, {31'd0, fast});
        fork
            capture_frame(div, got, slen, stop_b);
            begin
                write_reg(`IO_REGION, `IO_IDX_UART_DATA, {24'd0, b});
                txr_m = 1'b0;
                expect_read(`IO_IDX_UART_CTRL, "status during frame");
                write_reg(`IO_REGION, `IO_IDX_UART_DATA, {24'd0, ~b});   // line busy
            end
        join
        queue_check(K_BYTE, got, b, "transmitted byte");
        queue_check(K_WORD, slen, div, "transmit bit period");
        queue_check(K_WORD, stop_b, 1, "transmit stop bit");
        wait_status(1, 1'b1, "tx_ready did not return high after the frame");
        txr_m = 1'b1;
        lows  = 0;
        repeat (3 * div) begin
            @(negedge clk_cpu);
            lows += (tx_o === 1'b0);
        end
        queue_check(K_WORD, lows, 0, "tx_o idle after a write while busy");
    endtask

    task automatic receive_case(input logic fast, input int count);
        byte_t b;
        int    div;
        div    = fast ? DIV_FAST : DIV_SLOW;
        rate_m = fast;
        write_reg(`IO_REGION, `IO_IDX_UART_CTRL, {31'd0, fast});   // queue empty here
        for (int i = 0; i < count; i++) begin
            b = rand_byte();
            send_frame(b, div);
            if (rxq.size() < `RX_FIFO_DEPTH) begin
                rxq.push_back(b);
            end
        end
        while (rxq.size() > 0) begin
            wait_status(0, 1'b1, "rx_ready did not go high");
            expect_read(`IO_IDX_UART_CTRL, "status before dequeue");
            dequeue_byte();
            expect_read(`IO_IDX_UART_DATA, "received byte");
        end
        expect_read(`IO_IDX_UART_CTRL, "status with queue empty");
    endtask

    initial begin
        logic [31:0] w;
        int          cyc;
        clk_cpu   = 1'b0;
        rst_n     = 1'b0;
        rx_i      = 1'b1;
        req       = '0;
        lcg_state = 78825;
        cycles    = 0;
        led_m     = '0;
        rate_m    = 1'b0;
        txr_m     = 1'b1;
        last_byte = '0;
        repeat (3) @(negedge clk_cpu);
        rst_n = 1'b1;

        queue_check(K_BYTE, led, 8'h00, "led_o after reset");
        queue_check(K_WORD, tx_o, 1, "tx_o after reset");
        expect_read(`IO_IDX_UART_CTRL, "status after reset");
        expect_read(`IO_IDX_MS, "ms counter after reset");

        for (int i = 0; i < 8; i++) begin
            led_m = rand_byte();
            write_reg(`IO_REGION, `IO_IDX_LED, {24'd0, led_m});
            queue_check(K_BYTE, led, led_m, "led_o after write");
            expect_read(`IO_IDX_LED, "led word read");
        end
        write_reg(4'h3, `IO_IDX_LED, {24'd0, ~led_m});   // outside the IO region
        queue_check(K_BYTE, led, led_m, "led_o after write outside IO");
        read_reg(4'h3, `IO_IDX_UART_CTRL, w, cyc);      // status would read nonzero inside IO
        queue_check(K_WORD, w, 32'd0, "read outside IO");
        expect_read(4'd5, "unused word");

        for (int i = 0; i < 6; i++) begin
            repeat (rand_byte() % 64) @(negedge clk_cpu);
            expect_read(`IO_IDX_MS, "ms counter");
        end

        transmit_case(1'b0);
        transmit_case(1'b1);
        receive_case(1'b0, 5);
        receive_case(1'b1, `RX_FIFO_DEPTH + 2);

        repeat (2) @(negedge clk_cpu);
        if (checks.size() == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            fail_run("results left unchecked at the end of the run");
        end
    end

endmodule

//--- tb.f
+incdir+include
logic/io_pkg.sv
logic/ms_timer.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/rx_fifo.sv
logic/io_regs.sv
logic/io_hub.sv
verif/io_hub_chk.sv
verif/tb_io_hub.sv

//--- Bender.yml
package:
  name: io_hub

export_include_dirs:
  - include

sources:
  - logic/io_pkg.sv
  - logic/ms_timer.sv
  - logic/uart_tx.sv
  - logic/uart_rx.sv
  - logic/rx_fifo.sv
  - logic/io_regs.sv
  - logic/io_hub.sv
  - target: simulation
    files:
      - verif/io_hub_chk.sv
      - verif/tb_io_hub.sv
